/* fetch_unit.f */
+incdir+.
fetch_pkg.sv
fetch_pc.sv
fetch_align.sv
rvc_expander.sv
fetch_branch.sv
inst_queue.sv
fetch_unit.sv
tb_clock_gen.sv
fetch_unit_tb.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - fetch_pc.sv
      - fetch_align.sv
      - rvc_expander.sv
      - fetch_branch.sv
      - inst_queue.sv
      - fetch_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - fetch_unit_tb.sv

/* fetch_unit_tb.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module fetch_unit_tb
  import fetch_pkg::*;
;

  localparam int GOLD_N = 13;

  logic clk;
  logic rst;
  logic fetch_req;
  addr_t fetch_addr;
  logic resp_valid;
  addr_t resp_addr;
  inst_t resp_data;
  logic pred_taken;
  logic rob_ready;
  logic inst_valid;
  inst_t inst;
  addr_t inst_pc;
  logic inst_compressed;
  logic inst_pred_taken;
  logic flush;
  addr_t flush_pc;

  inst_t mem [64];
  logic pt_mem [64];
  addr_t gold_pc [GOLD_N];
  inst_t gold_inst [GOLD_N];
  logic gold_c [GOLD_N];
  logic gold_pt [GOLD_N];

  addr_t addr_q [$];
  int due_q [$];
  integer seed;
  int cyc;
  int due;
  int gidx;
  int checked;
  int errors;
  int tests;
  int err_start;
  logic hold_low;
  logic flush_d;
  int sent;
  int got;
  int got_d1;
  int got_d2;
  int got_d3;
  int out_prev;
  int need_prev;

  tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));

  fetch_unit dut_i (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .resp_valid(resp_valid), .resp_addr(resp_addr), .resp_data(resp_data),
    .pred_taken(pred_taken), .rob_ready(rob_ready), .inst_valid(inst_valid),
    .inst(inst), .inst_pc(inst_pc), .inst_compressed(inst_compressed),
    .inst_pred_taken(inst_pred_taken), .flush(flush), .flush_pc(flush_pc)
  );

  function automatic int find_index(addr_t pc);
    for (int i = 0; i < GOLD_N; i++) begin
      if (gold_pc[i] == pc) return i;
    end
    return 0;
  endfunction

  // Cache model with in-order random latency, also drives rob_ready
  always @(posedge clk) begin
    cyc++;
    if (rst) begin
      resp_valid <= 1'b0;
      addr_q.delete();
      due_q.delete();
    end else begin
      resp_valid <= 1'b0;
      if (addr_q.size() > 0 && due_q[0] <= cyc) begin
        resp_valid <= 1'b1;
        resp_addr <= addr_q[0];
        resp_data <= mem[addr_q[0][7:2]];
        pred_taken <= pt_mem[addr_q[0][7:2]];
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (fetch_req) begin
        due = cyc + 1 + ({$random(seed)} % 3);
        if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;  // Keep order
        addr_q.push_back(fetch_addr);
        due_q.push_back(due);
      end
      assert (addr_q.size() <= `FU_MAX_INFLIGHT) else begin
        $display("More than %0d fetch requests outstanding", `FU_MAX_INFLIGHT);
        errors++;
      end
      rob_ready <= hold_low ? 1'b0 : (({$random(seed)} % 3) != 0);
    end
  end

  // Output checker against the golden program walk
  always @(posedge clk) begin
    if (!rst) begin
      if (inst_valid) begin
        assert (inst_pc == gold_pc[gidx]) else begin
          $display("CHECK FAILED inst_pc exp %h got %h", gold_pc[gidx], inst_pc);
          errors++;
        end
        assert (inst == gold_inst[gidx]) else begin
          $display("CHECK FAILED inst exp %h got %h", gold_inst[gidx], inst);
          errors++;
        end
        assert (inst_compressed == gold_c[gidx]) else begin
          $display("CHECK FAILED inst_compressed exp %h got %h", gold_c[gidx], inst_compressed);
          errors++;
        end
        assert (inst_pred_taken == gold_pt[gidx]) else begin
          $display("CHECK FAILED inst_pred_taken exp %h got %h", gold_pt[gidx], inst_pred_taken);
          errors++;
        end
        gidx = (gidx + 1) % GOLD_N;
        checked++;
      end
      assert (!(flush_d && inst_valid)) else begin
        $display("inst_valid was high in the cycle after a flush");
        errors++;
      end
      assert (dut_i.iq_count <= `FU_IQ_DEPTH) else begin
        $display("CHECK FAILED iq_count exp <= %h got %h", `FU_IQ_DEPTH, dut_i.iq_count);
        errors++;
      end
      assert (!(fetch_req && (out_prev >= `FU_MAX_INFLIGHT || need_prev > `FU_IQ_DEPTH)))
      else begin
        $display("fetch_req issued beyond the queue room or the in-flight limit");
        errors++;
      end
      if (flush) gidx = find_index(flush_pc);  // New stream starts at flush_pc
      // A request stays outstanding until three cycles after its response
      sent += int'(fetch_req);
      got_d3 = got_d2;
      got_d2 = got_d1;
      got_d1 = got;
      got += int'(resp_valid);
      out_prev = sent - got_d3;
      need_prev = int'(dut_i.iq_count) + 2 * out_prev + 2;
    end
    flush_d = flush;
  end

  task automatic wait_checks(input int target, input int limit, input string what);
    int n;
    n = 0;
    while (checked < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (checked < target) begin
      $display("Timeout in %s: %0d of %0d instructions seen", what, checked, target);
      errors++;
    end
  endtask

  task automatic pulse_flush(input addr_t pc);
    @(posedge clk);
    flush <= 1'b1;
    flush_pc <= pc;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %0d errors", name, errors - err_start);
    err_start = errors;
  endtask

  initial begin
    int n;
    seed = 32'h2950;
    cyc = 0;
    gidx = 0;
    checked = 0;
    errors = 0;
    tests = 0;
    err_start = 0;
    hold_low = 1'b0;
    flush_d = 1'b0;
    sent = 0;
    got = 0;
    got_d1 = 0;
    got_d2 = 0;
    got_d3 = 0;
    out_prev = 0;
    need_prev = 0;
    flush = 1'b0;
    flush_pc = '0;
    resp_valid = 1'b0;
    resp_addr = '0;
    resp_data = '0;
    pred_taken = 1'b0;
    rob_ready = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h0000_0013 | (32'(i) << 20);  // addi x0 filler tagged by address
      pt_mem[i] = 1'b0;
    end
    mem[0] = 32'h0010_0093;
    mem[1] = 32'h0020_0113;
    mem[2] = 32'h0030_0193;
    mem[3] = 32'h0289_4285;   // C.LI x5,1 then C.ADDI x5,2
    mem[4] = 32'h0393_8316;   // C.MV x6,x5 then low half of addi x7
    mem[5] = 32'hA029_0070;   // C.J to 0x20 in lane1
    mem[8] = 32'h4F85_A801;   // C.J to 0x30 in lane0
    mem[12] = 32'h0000_0463;  // beq to 0x38
    pt_mem[12] = 1'b1;
    mem[14] = 32'h0000_1863;  // bne, not predicted
    mem[15] = 32'h0080_0413;
    mem[16] = 32'hFC1F_F06F;  // jal back to 0
    gold_pc = '{32'h00, 32'h04, 32'h08, 32'h0C, 32'h0E, 32'h10, 32'h12,
                32'h16, 32'h20, 32'h30, 32'h38, 32'h3C, 32'h40};
    gold_inst = '{32'h0010_0093, 32'h0020_0113, 32'h0030_0193, 32'h0010_0293,
                  32'h0022_8293, 32'h0050_0333, 32'h0070_0393, 32'h00A0_006F,
                  32'h0100_006F, 32'h0000_0463, 32'h0000_1863, 32'h0080_0413,
                  32'hFC1F_F06F};
    gold_c = '{0, 0, 0, 1, 1, 1, 0, 1, 1, 0, 0, 0, 0};
    gold_pt = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0};

    n = 0;
    while (rst !== 1'b0 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("Reset never released");
      errors++;
    end

    wait_checks(checked + 3 * GOLD_N, 3000, "program_walk");
    end_test("program_walk");

    hold_low <= 1'b1;
    repeat (60) @(posedge clk);  // Queue fills and fetch stalls
    hold_low <= 1'b0;
    wait_checks(checked + 2 * GOLD_N, 3000, "rob_stall");
    end_test("rob_stall");

    pulse_flush(32'h0E);
    wait_checks(checked + GOLD_N, 2000, "flush_halfword");
    end_test("flush_halfword");

    pulse_flush(32'h30);
    wait_checks(checked + GOLD_N, 2000, "flush_branch");
    end_test("flush_branch");

    $display("tests %0d, instructions checked %0d, errors %0d", tests, checked, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module fetch_unit
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output logic  fetch_req,
  output addr_t fetch_addr,
  input  logic  resp_valid,
  input  addr_t resp_addr,
  input  inst_t resp_data,
  input  logic  pred_taken,
  input  logic  rob_ready,
  output logic  inst_valid,
  output inst_t inst,
  output addr_t inst_pc,
  output logic  inst_compressed,
  output logic  inst_pred_taken,
  input  logic  flush,
  input  addr_t flush_pc
);

  logic exp_valid;
  addr_t exp_pc;
  logic redirect;
  addr_t redirect_pc;
  iq_count_t iq_count;

  logic lane0_valid;
  logic lane1_valid;
  inst_t lane0_raw;
  inst_t lane1_raw;
  addr_t lane0_pc;
  addr_t lane1_pc;
  logic lane0_compressed;
  logic lane1_compressed;
  logic lane_pred_taken;
  inst_t lane0_expanded;
  inst_t lane1_expanded;

  logic wr0_valid;
  logic wr1_valid;
  inst_t wr0_inst;
  inst_t wr1_inst;
  addr_t wr0_pc;
  addr_t wr1_pc;
  logic wr0_compressed;
  logic wr1_compressed;
  logic wr0_pred_taken;
  logic wr1_pred_taken;

  fetch_pc pc_i (
    .clk(clk), .rst(rst), .flush(flush), .flush_pc(flush_pc),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .resp_valid(resp_valid), .iq_count(iq_count),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .exp_valid(exp_valid), .exp_pc(exp_pc)
  );

  fetch_align align_i (
    .clk(clk), .rst(rst), .flush(flush), .exp_valid(exp_valid), .exp_pc(exp_pc),
    .resp_valid(resp_valid), .resp_addr(resp_addr), .resp_data(resp_data),
    .pred_taken(pred_taken),
    .lane0_valid(lane0_valid), .lane1_valid(lane1_valid),
    .lane0_raw(lane0_raw), .lane1_raw(lane1_raw),
    .lane0_pc(lane0_pc), .lane1_pc(lane1_pc),
    .lane0_compressed(lane0_compressed), .lane1_compressed(lane1_compressed),
    .lane_pred_taken(lane_pred_taken)
  );

  rvc_expander exp0_i (.parcel(lane0_raw[15:0]), .expanded(lane0_expanded));
  rvc_expander exp1_i (.parcel(lane1_raw[15:0]), .expanded(lane1_expanded));

  fetch_branch branch_i (
    .clk(clk), .rst(rst), .flush(flush),
    .lane0_valid(lane0_valid), .lane1_valid(lane1_valid),
    .lane0_raw(lane0_raw), .lane1_raw(lane1_raw),
    .lane0_pc(lane0_pc), .lane1_pc(lane1_pc),
    .lane0_compressed(lane0_compressed), .lane1_compressed(lane1_compressed),
    .lane_pred_taken(lane_pred_taken),
    .lane0_expanded(lane0_expanded), .lane1_expanded(lane1_expanded),
    .wr0_valid(wr0_valid), .wr1_valid(wr1_valid),
    .wr0_inst(wr0_inst), .wr1_inst(wr1_inst),
    .wr0_pc(wr0_pc), .wr1_pc(wr1_pc),
    .wr0_compressed(wr0_compressed), .wr1_compressed(wr1_compressed),
    .wr0_pred_taken(wr0_pred_taken), .wr1_pred_taken(wr1_pred_taken),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  inst_queue iq_i (
    .clk(clk), .rst(rst), .flush(flush),
    .wr0_valid(wr0_valid), .wr0_inst(wr0_inst), .wr0_pc(wr0_pc),
    .wr0_compressed(wr0_compressed), .wr0_pred_taken(wr0_pred_taken),
    .wr1_valid(wr1_valid), .wr1_inst(wr1_inst), .wr1_pc(wr1_pc),
    .wr1_compressed(wr1_compressed), .wr1_pred_taken(wr1_pred_taken),
    .rob_ready(rob_ready), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
    .inst_compressed(inst_compressed), .inst_pred_taken(inst_pred_taken),
    .iq_count(iq_count)
  );

endmodule

/* inst_queue.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module inst_queue
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  logic      wr0_valid,
  input  inst_t     wr0_inst,
  input  addr_t     wr0_pc,
  input  logic      wr0_compressed,
  input  logic      wr0_pred_taken,
  input  logic      wr1_valid,
  input  inst_t     wr1_inst,
  input  addr_t     wr1_pc,
  input  logic      wr1_compressed,
  input  logic      wr1_pred_taken,
  input  logic      rob_ready,
  output logic      inst_valid,
  output inst_t     inst,
  output addr_t     inst_pc,
  output logic      inst_compressed,
  output logic      inst_pred_taken,
  output iq_count_t iq_count
);

  inst_t inst_mem [`FU_IQ_DEPTH];
  addr_t pc_mem [`FU_IQ_DEPTH];
  logic c_mem [`FU_IQ_DEPTH];
  logic pt_mem [`FU_IQ_DEPTH];

  iq_ptr_t head;
  iq_ptr_t tail;
  iq_ptr_t tail1;  // Slot for wr1, right after wr0
  iq_count_t count;
  logic rd;

  assign rd = rob_ready && (count != '0);
  assign tail1 = tail + iq_ptr_t'(wr0_valid);
  assign iq_count = count;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= rd;
      head <= head + iq_ptr_t'(rd);
      tail <= tail1 + iq_ptr_t'(wr1_valid);
      count <= count + iq_count_t'(wr0_valid) + iq_count_t'(wr1_valid) - iq_count_t'(rd);
    end
  end

  always_ff @(posedge clk) begin
    if (wr0_valid) begin
      inst_mem[tail] <= wr0_inst;
      pc_mem[tail] <= wr0_pc;
      c_mem[tail] <= wr0_compressed;
      pt_mem[tail] <= wr0_pred_taken;
    end
    if (wr1_valid) begin
      inst_mem[tail1] <= wr1_inst;
      pc_mem[tail1] <= wr1_pc;
      c_mem[tail1] <= wr1_compressed;
      pt_mem[tail1] <= wr1_pred_taken;
    end
    if (rd) begin
      inst <= inst_mem[head];
      inst_pc <= pc_mem[head];
      inst_compressed <= c_mem[head];
      inst_pred_taken <= pt_mem[head];
    end
  end

endmodule

/* fetch_branch.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module fetch_branch
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  logic  lane0_valid,
  input  logic  lane1_valid,
  input  inst_t lane0_raw,
  input  inst_t lane1_raw,
  input  addr_t lane0_pc,
  input  addr_t lane1_pc,
  input  logic  lane0_compressed,
  input  logic  lane1_compressed,
  input  logic  lane_pred_taken,
  input  inst_t lane0_expanded,
  input  inst_t lane1_expanded,
  output logic  wr0_valid,
  output logic  wr1_valid,
  output inst_t wr0_inst,
  output inst_t wr1_inst,
  output addr_t wr0_pc,
  output addr_t wr1_pc,
  output logic  wr0_compressed,
  output logic  wr1_compressed,
  output logic  wr0_pred_taken,
  output logic  wr1_pred_taken,
  output logic  redirect,
  output addr_t redirect_pc
);

  function automatic logic takes_jump(inst_t w, logic pred);
    return (w[6:0] == `FU_OPC_JAL) || ((w[6:0] == `FU_OPC_BRANCH) && pred);
  endfunction

  function automatic addr_t jump_target(inst_t w, addr_t pc);
    addr_t imm;
    if (w[6:0] == `FU_OPC_JAL) begin
      imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};  // J-immediate
    end else begin
      imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};    // B-immediate
    end
    return pc + imm;
  endfunction

  inst_t word0;
  inst_t word1;
  logic live0;
  logic live1;
  logic take0;
  logic take1;

  assign word0 = lane0_compressed ? lane0_expanded : lane0_raw;
  assign word1 = lane1_compressed ? lane1_expanded : lane1_raw;
  assign live0 = lane0_valid && !redirect;  // Lanes behind a redirect are wrong path
  assign take0 = live0 && takes_jump(word0, lane_pred_taken);
  assign live1 = lane1_valid && !redirect && !take0;
  assign take1 = live1 && takes_jump(word1, lane_pred_taken);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr0_valid <= 1'b0;
      wr1_valid <= 1'b0;
      redirect <= 1'b0;
    end else begin
      wr0_valid <= live0;
      wr1_valid <= live1;
      redirect <= take0 || take1;
    end
  end

  always_ff @(posedge clk) begin
    wr0_inst <= word0;
    wr0_pc <= lane0_pc;
    wr0_compressed <= lane0_compressed;
    wr0_pred_taken <= lane_pred_taken;
    wr1_inst <= word1;
    wr1_pc <= lane1_pc;
    wr1_compressed <= lane1_compressed;
    wr1_pred_taken <= lane_pred_taken;
    redirect_pc <= take0 ? jump_target(word0, lane0_pc) : jump_target(word1, lane1_pc);
  end

endmodule

/* rvc_expander.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module rvc_expander
  import fetch_pkg::*;
(
  input  parcel_t parcel,
  output inst_t   expanded
);

  parcel_t c;
  logic [4:0] rd;
  logic [4:0] rs2;
  logic [2:0] rdp;
  logic [2:0] rs1p;

  assign c = parcel;
  assign rd = c[11:7];
  assign rs2 = c[6:2];
  assign rdp = c[4:2];   // Also rs2' in stores
  assign rs1p = c[9:7];

  always_comb begin
    expanded = '0;
    case (c[1:0])
      2'b00: begin
        case (c[15:13])
          3'b000: begin  // C.ADDI4SPN
            if (c[12:5] != 8'h00) begin
              expanded = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                          5'd2, 3'b000, 2'b01, rdp, 7'b0010011};
            end
          end
          3'b010: begin  // C.LW
            expanded = {5'b00000, c[5], c[12:10], c[6], 2'b00,
                        2'b01, rs1p, 3'b010, 2'b01, rdp, 7'b0000011};
          end
          3'b110: begin  // C.SW
            expanded = {5'b00000, c[5], c[12], 2'b01, rdp, 2'b01, rs1p,
                        3'b010, c[11:10], c[6], 2'b00, 7'b0100011};
          end
          default: expanded = '0;
        endcase
      end
      2'b01: begin
        case (c[15:13])
          3'b000: expanded = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, 7'b0010011};  // C.ADDI
          3'b001: begin  // C.JAL
            expanded = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                        {9{c[12]}}, 5'd1, `FU_OPC_JAL};
          end
          3'b010: expanded = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, 7'b0010011};  // C.LI
          3'b011: begin
            if (rd == 5'd2) begin
              if ({c[12], c[6:2]} != 6'd0) begin  // C.ADDI16SP
                expanded = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                            5'd2, 3'b000, 5'd2, 7'b0010011};
              end
            end else if ({c[12], c[6:2]} != 6'd0) begin  // C.LUI
              expanded = {{15{c[12]}}, c[6:2], rd, 7'b0110111};
            end
          end
          3'b101: begin  // C.J
            expanded = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                        {9{c[12]}}, 5'd0, `FU_OPC_JAL};
          end
          3'b110, 3'b111: begin  // C.BEQZ and C.BNEZ
            expanded = {{4{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, rs1p, 2'b00, c[13],
                        c[11:10], c[4:3], c[12], `FU_OPC_BRANCH};
          end
          default: expanded = '0;  // Arithmetic group not supported
        endcase
      end
      2'b10: begin
        case (c[15:13])
          3'b000: begin  // C.SLLI
            if (!c[12]) begin
              expanded = {7'b0000000, c[6:2], rd, 3'b001, rd, 7'b0010011};
            end
          end
          3'b010: begin  // C.LWSP
            expanded = {4'b0000, c[3:2], c[12], c[6:4], 2'b00,
                        5'd2, 3'b010, rd, 7'b0000011};
          end
          3'b110: begin  // C.SWSP
            expanded = {4'b0000, c[8:7], c[12], rs2, 5'd2, 3'b010,
                        c[11:9], 2'b00, 7'b0100011};
          end
          3'b100: begin
            if (!c[12]) begin
              if (rs2 != 5'd0) begin
                expanded = {7'b0000000, rs2, 5'd0, 3'b000, rd, 7'b0110011};  // C.MV
              end else if (rd != 5'd0) begin
                expanded = {12'h000, rd, 3'b000, 5'd0, 7'b1100111};  // C.JR
              end
            end else begin
              if (rs2 != 5'd0) begin
                expanded = {7'b0000000, rs2, rd, 3'b000, rd, 7'b0110011};  // C.ADD
              end else if (rd != 5'd0) begin
                expanded = {12'h000, rd, 3'b000, 5'd1, 7'b1100111};  // C.JALR
              end
            end
          end
          default: expanded = '0;
        endcase
      end
      default: expanded = '0;
    endcase
  end

endmodule

/* fetch_align.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module fetch_align
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  logic  exp_valid,
  input  addr_t exp_pc,
  input  logic  resp_valid,
  input  addr_t resp_addr,
  input  inst_t resp_data,
  input  logic  pred_taken,
  output logic  lane0_valid,
  output logic  lane1_valid,
  output inst_t lane0_raw,
  output inst_t lane1_raw,
  output addr_t lane0_pc,
  output addr_t lane1_pc,
  output logic  lane0_compressed,
  output logic  lane1_compressed,
  output logic  lane_pred_taken
);

  align_state_t state;
  addr_t exp_q;      // Pc of the next parcel to consume
  parcel_t half_q;   // Lower half of a straddling instruction
  parcel_t lo;
  parcel_t hi;
  addr_t word;
  logic accept;
  logic take_hi;
  logic hold;
  logic n0_valid;
  logic n1_valid;
  logic n0_c;
  inst_t n0_raw;
  addr_t n0_pc;

  assign lo = resp_data[15:0];
  assign hi = resp_data[31:16];
  assign word = {resp_addr[`FU_XLEN-1:2], 2'b00};
  assign accept = resp_valid && !exp_valid &&
                  (resp_addr[`FU_XLEN-1:2] == exp_q[`FU_XLEN-1:2]);  // Drop stale words

  always_comb begin
    n0_valid = 1'b0;
    n1_valid = 1'b0;
    n0_raw = resp_data;
    n0_pc = word;
    n0_c = 1'b0;
    take_hi = 1'b1;
    if (state == ALIGN_HALF) begin
      n0_valid = 1'b1;
      n0_raw = {lo, half_q};
      n0_pc = word - 2;
    end else if (!exp_q[1]) begin
      n0_valid = 1'b1;
      if (lo[1:0] == 2'b11) begin
        take_hi = 1'b0;  // Full 32-bit word
      end else begin
        n0_raw = {16'h0000, lo};
        n0_c = 1'b1;
      end
    end
    hold = take_hi && (hi[1:0] == 2'b11);
    if (take_hi && !hold) begin
      if (n0_valid) begin
        n1_valid = 1'b1;
      end else begin
        n0_valid = 1'b1;
        n0_raw = {16'h0000, hi};
        n0_pc = word + 2;
        n0_c = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ALIGN_EMPTY;
      exp_q <= `FU_RESET_PC;
      lane0_valid <= 1'b0;
      lane1_valid <= 1'b0;
    end else if (flush || exp_valid) begin
      state <= ALIGN_EMPTY;
      exp_q <= exp_pc;
      lane0_valid <= 1'b0;
      lane1_valid <= 1'b0;
    end else begin
      lane0_valid <= accept && n0_valid;
      lane1_valid <= accept && n1_valid;
      if (accept) begin
        state <= hold ? ALIGN_HALF : ALIGN_EMPTY;
        exp_q <= word + 4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lane0_raw <= n0_raw;
      lane0_pc <= n0_pc;
      lane0_compressed <= n0_c;
      lane1_raw <= {16'h0000, hi};
      lane1_pc <= word + 2;
      lane1_compressed <= 1'b1;  // Lane1 only ever carries the upper parcel
      lane_pred_taken <= pred_taken;
      if (hold) begin
        half_q <= hi;
      end
    end
  end

endmodule

/* fetch_pc.sv */
`timescale 1ns/1ns
`include "fetch_unit_macros.svh"

module fetch_pc
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  addr_t     flush_pc,
  input  logic      redirect,
  input  addr_t     redirect_pc,
  input  logic      resp_valid,
  input  iq_count_t iq_count,
  output logic      fetch_req,
  output addr_t     fetch_addr,
  output logic      exp_valid,
  output addr_t     exp_pc
);

  localparam int CNT_W = $clog2(`FU_MAX_INFLIGHT + 1);
  localparam addr_t WORD_MASK = ~addr_t'(3);

  logic [CNT_W-1:0] inflight;  // Live requests not yet written to the queue
  logic [CNT_W-1:0] stale;     // Requests abandoned by a flush
  logic [CNT_W:0] total;
  logic [`FU_IQ_PTR_W+1:0] need;
  logic resp_d1;
  logic retire;
  logic issue;

  assign total = inflight + stale;
  assign need = iq_count + (total << 1) + 2;  // Worst case two entries per word
  assign issue = (total < `FU_MAX_INFLIGHT) && (need <= `FU_IQ_DEPTH);

  assign exp_valid = flush | redirect;
  assign exp_pc = flush ? flush_pc : redirect_pc;

  // A word lands in the queue two cycles after its response
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_d1 <= 1'b0;
      retire <= 1'b0;
    end else begin
      resp_d1 <= resp_valid;
      retire <= resp_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_req <= 1'b0;
      fetch_addr <= `FU_RESET_PC & WORD_MASK;
      inflight <= '0;
      stale <= '0;
    end else begin
      fetch_req <= issue;
      if (flush) begin
        fetch_addr <= flush_pc & WORD_MASK;  // Flush wins over redirect
      end else if (redirect) begin
        fetch_addr <= redirect_pc & WORD_MASK;
      end else if (fetch_req) begin
        fetch_addr <= fetch_addr + 4;
      end
      if (flush) begin
        inflight <= CNT_W'(issue);
        stale <= stale + inflight - CNT_W'(retire);
      end else if (retire && stale != '0) begin
        stale <= stale - 1'b1;
        inflight <= inflight + CNT_W'(issue);
      end else begin
        inflight <= inflight + CNT_W'(issue) - CNT_W'(retire);
      end
    end
  end

endmodule

/* fetch_pkg.sv */
`include "fetch_unit_macros.svh"

package fetch_pkg;

  // Byte address
  typedef logic [`FU_XLEN-1:0] addr_t;

  // Full 32-bit instruction word
  typedef logic [`FU_XLEN-1:0] inst_t;

  typedef logic [15:0] parcel_t;

  typedef logic [`FU_IQ_PTR_W-1:0] iq_ptr_t;
  typedef logic [`FU_IQ_PTR_W:0] iq_count_t;  // One extra bit to tell full from empty

  typedef enum logic {
    ALIGN_EMPTY,
    ALIGN_HALF
  } align_state_t;

endpackage

/* fetch_unit_macros.svh */
`ifndef FETCH_UNIT_MACROS_SVH
`define FETCH_UNIT_MACROS_SVH

// Datapath widths
`define FU_XLEN 32

// Instruction queue sizing
`define FU_IQ_DEPTH 16
`define FU_IQ_PTR_W 4

// Most requests the cache may hold at once
`define FU_MAX_INFLIGHT 2

`define FU_RESET_PC 32'h0000_0000

// Major opcodes seen by the control-flow stage
`define FU_OPC_BRANCH 7'b1100011
`define FU_OPC_JAL 7'b1101111

`endif
